// File: cpu6809.f
hdl/cpu_pkg.sv
hdl/vector_loader.sv
hdl/fetch_unit.sv
hdl/op_decode.sv
hdl/alu.sv
hdl/exec_regs.sv
hdl/cpu_core.sv
dv/clk_gen.sv
dv/cpu_asserts.sv
dv/tb_cpu.sv

// File: Makefile
# Verilator build and run for the cpu6809 testbench

TOP := tb_cpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f cpu6809.f -Mdir obj_dir

# Pass only when the simulation prints the pass message
run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q 'TEST RESULT: PASS'

clean:
	rm -rf obj_dir

// File: dv/tb_cpu.sv
// Testbench top with memory model, program table, xorshift operands and trace checks

`timescale 1ns/100ps

module tb_cpu import cpu_pkg::*; ();

  localparam int    TIMEOUT_CYCLES = 20;
  localparam addr_t PROG_BASE      = 16'h0200;

  // One program table row with its expected post-execute state
  typedef struct packed {
    byte_t      opcode;
    byte_t      exp_a;
    byte_t      exp_b;
    logic [3:0] exp_nzvc;
    addr_t      exp_pc;
  } step_t;

  logic   clk;
  logic   reset_b;
  byte_t  data_in = 8'h00;
  addr_t  addr;
  logic   retire;
  trace_t trace;

  byte_t       mem [0:65535];
  step_t       steps [$];
  string       step_names [$];
  logic [31:0] rng_state;
  logic        fail_reported;
  logic        run_passed;

  // Model state while the table is built
  byte_t      model_a;
  byte_t      model_b;
  logic [3:0] model_nzvc;
  addr_t      load_addr;

  clk_gen i_clk_gen (
    .clk     (clk),
    .reset_b (reset_b)
  );

  cpu_core i_dut (
    .clk     (clk),
    .reset_b (reset_b),
    .data_in (data_in),
    .addr    (addr),
    .retire  (retire),
    .trace   (trace)
  );

  // Zero wait-state read port
  always @(negedge clk) begin
    data_in <= mem[addr];
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic byte_t random_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < 65536; i++) begin
      mem[i] = byte_t'(i >> 8) ^ byte_t'(i) ^ 8'h5a;
    end
    // Vector points at the program
    mem[16'hfffe] = PROG_BASE[15:8];
    mem[16'hffff] = PROG_BASE[7:0];
  endtask

  // Places one instruction and steps the expected state by the opcode rules
  task automatic add_step(input string name, input byte_t opcode, input byte_t operand);
    step_t s;
    byte_t val;
    logic  is_ld;
    logic  use_b;
    logic  known;
    logic  v;
    logic  c;
    is_ld = (opcode == 8'h86) || (opcode == 8'hc6);
    use_b = (opcode == 8'hc6) || (opcode[7:4] == 4'h5);
    val   = use_b ? model_b : model_a;
    v     = model_nzvc[1];
    c     = model_nzvc[0];
    known = 1'b1;
    if (is_ld) begin
      val = operand;
      v   = 1'b0;
    end else if (opcode[7:4] == 4'h4 || opcode[7:4] == 4'h5) begin
      case (opcode[3:0])
        4'hf: begin
          val = 8'h00;
          v   = 1'b0;
          c   = 1'b0;
        end
        4'hc: begin
          val = val + 8'd1;
          v   = (val == 8'h80);
        end
        4'h3: begin
          val = ~val;
          v   = 1'b0;
          c   = 1'b1;
        end
        4'h8: begin
          c   = val[7];
          val = val << 1;
          v   = val[7] ^ c;
        end
        4'h9: begin
          {c, val} = {val, c};
          v        = val[7] ^ c;
        end
        4'h4: begin
          c   = val[0];
          val = val >> 1;
          v   = val[7] ^ c;
        end
        4'h7: begin
          c   = val[0];
          val = {val[7], val[7:1]};
          v   = val[7] ^ c;
        end
        4'h6: begin
          {val, c} = {c, val};
          v        = val[7] ^ c;
        end
        default: known = 1'b0;
      endcase
    end else begin
      known = 1'b0;
    end
    // Unsupported bytes leave everything alone
    if (known) begin
      if (use_b) begin
        model_b = val;
      end else begin
        model_a = val;
      end
      model_nzvc = {val[7], val == 8'h00, v, c};
    end
    mem[load_addr] = opcode;
    load_addr      = load_addr + 16'd1;
    if (is_ld) begin
      mem[load_addr] = operand;
      load_addr      = load_addr + 16'd1;
    end
    s.opcode   = opcode;
    s.exp_a    = model_a;
    s.exp_b    = model_b;
    s.exp_nzvc = model_nzvc;
    s.exp_pc   = load_addr;
    steps.push_back(s);
    step_names.push_back(name);
  endtask

  task automatic build_program();
    // Random immediate loads
    add_step("lda_rand_0", 8'h86, random_byte());
    add_step("ldb_rand_0", 8'hc6, random_byte());
    add_step("lda_rand_1", 8'h86, random_byte());
    add_step("ldb_rand_1", 8'hc6, random_byte());
    // A operators around 7f, 80 and 00
    add_step("lda_7f", 8'h86, 8'h7f);
    add_step("inca_to_80", 8'h4c, 8'h00);
    add_step("coma", 8'h43, 8'h00);
    add_step("lda_80", 8'h86, 8'h80);
    add_step("asra_80", 8'h47, 8'h00);
    add_step("lsra", 8'h44, 8'h00);
    add_step("lda_00", 8'h86, 8'h00);
    add_step("inca_from_00", 8'h4c, 8'h00);
    add_step("clra", 8'h4f, 8'h00);
    add_step("rora_zero", 8'h46, 8'h00);
    // Same set on B
    add_step("ldb_7f", 8'hc6, 8'h7f);
    add_step("incb_to_80", 8'h5c, 8'h00);
    add_step("comb", 8'h53, 8'h00);
    add_step("ldb_01", 8'hc6, 8'h01);
    add_step("lsrb_01", 8'h54, 8'h00);
    add_step("ldb_ff", 8'hc6, 8'hff);
    add_step("asrb_ff", 8'h57, 8'h00);
    add_step("clrb", 8'h5f, 8'h00);
    // Carry out of ASL fed through ROL and ROR
    add_step("lda_81", 8'h86, 8'h81);
    add_step("asla_81", 8'h48, 8'h00);
    add_step("rola", 8'h49, 8'h00);
    add_step("rora", 8'h46, 8'h00);
    add_step("ldb_80", 8'hc6, 8'h80);
    add_step("aslb_80", 8'h58, 8'h00);
    add_step("rolb", 8'h59, 8'h00);
    add_step("rorb_0", 8'h56, 8'h00);
    add_step("rorb_1", 8'h56, 8'h00);
    // Bytes retired as no-ops
    add_step("nop_12", 8'h12, 8'h00);
    add_step("nop_40", 8'h40, 8'h00);
    add_step("lda_rand_2", 8'h86, random_byte());
  endtask

  // --------------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------------
  task automatic stop_on_error();
    fail_reported = 1'b1;
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input string field,
                             input logic [15:0] expected, input logic [15:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", name, field, expected, actual);
      stop_on_error();
    end
  endtask

  // Counts falling edges until retire shows up
  task automatic wait_retire(input string name, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!retire && cycles < TIMEOUT_CYCLES);
    assert (retire) else begin
      $display("Timeout: %s never retired within %0d cycles", name, TIMEOUT_CYCLES);
      stop_on_error();
    end
  endtask

  initial begin
    int    cycles;
    int    exp_gap;
    step_t s;
    addr_t reset_addr;
    rng_state     = 32'd92;
    fail_reported = 1'b0;
    run_passed    = 1'b0;
    model_a       = 8'h00;
    model_b       = 8'h00;
    model_nzvc    = CC_RESET[3:0];
    load_addr     = PROG_BASE;
    reset_addr    = '0;
    fill_memory();
    build_program();

    // Reset release, sampled on falling edges
    // Last address seen with reset still low carries into the first cycle
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (reset_b !== 1'b1) begin
        reset_addr = addr;
      end
    end while (reset_b !== 1'b1 && cycles < TIMEOUT_CYCLES);
    assert (reset_b === 1'b1) else begin
      $display("Timeout: reset was never released");
      stop_on_error();
    end

    // Vector fetch sequence
    check_value("reset_vector", "addr cycle 1", 16'hfffe, reset_addr);
    check_value("reset_vector", "addr cycle 2", 16'hffff, addr);
    @(negedge clk);
    check_value("reset_vector", "addr cycle 3", PROG_BASE, addr);

    // Program table
    for (int i = 0; i < steps.size(); i++) begin
      s = steps[i];
      wait_retire(step_names[i], cycles);
      // Loads take one cycle more than inherent ops
      if (i > 0) begin
        exp_gap = ((s.opcode == 8'h86) || (s.opcode == 8'hc6)) ? 2 : 1;
        check_value(step_names[i], "retire gap", 16'(exp_gap), 16'(cycles));
      end
      check_value(step_names[i], "pc", s.exp_pc, trace.pc);
      check_value(step_names[i], "a", {8'h00, s.exp_a}, {8'h00, trace.a});
      check_value(step_names[i], "b", {8'h00, s.exp_b}, {8'h00, trace.b});
      check_value(step_names[i], "cc", {8'h00, CC_RESET[7:4], s.exp_nzvc}, {8'h00, trace.cc});
    end

    run_passed = 1'b1;
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Run ended before the table finished
  final begin
    if (!run_passed && !fail_reported) begin
      $display("TEST RESULT: FAIL");
    end
  end

endmodule

// File: dv/cpu_asserts.sv
// Bound assertions on exec to retire timing, destination selects and CC upper bits

`timescale 1ns/100ps

module cpu_asserts import cpu_pkg::*; (
  input logic      clk,
  input logic      reset_b,
  input logic      exec,
  input logic      retire,
  input alu_ctrl_t ctrl,
  input byte_t     cc
);

  // Retire lags exec by exactly one cycle
  exec_then_retire: assert property (@(posedge clk) disable iff (!reset_b) exec |=> retire)
    else $error("retire did not follow exec");

  retire_after_exec: assert property (@(posedge clk) disable iff (!reset_b)
    retire |-> $past(exec))
    else $error("retire without exec in the previous cycle");

  // Same ctrl word the ALU sees
  one_destination: assert property (@(posedge clk) disable iff (!reset_b)
    !(ctrl.dest_a && ctrl.dest_b))
    else $error("ctrl selects both accumulators");

  // E, F, H and I frozen at their reset values
  cc_upper_fixed: assert property (@(posedge clk) disable iff (!reset_b)
    cc[7:4] == CC_RESET[7:4])
    else $error("CC bits 7 to 4 moved away from reset value");

endmodule

bind exec_regs cpu_asserts i_cpu_asserts (
  .clk     (clk),
  .reset_b (reset_b),
  .exec    (exec),
  .retire  (retire),
  .ctrl    (ctrl),
  .cc      (cc)
);

// File: dv/clk_gen.sv
// Testbench clock and power-on reset generator

`timescale 1ns/100ps

module clk_gen (
  output logic clk,
  output logic reset_b
);

  // 40 ns period
  localparam int HALF_PERIOD = 20;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Low for five full cycles, released on a falling edge
  initial begin
    reset_b = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_b <= 1'b1;
  end

endmodule

// File: hdl/cpu_core.sv
// CPU core top level with unit wiring and the address bus multiplexer

`timescale 1ns/100ps

module cpu_core import cpu_pkg::*; (
  input  logic   clk,
  input  logic   reset_b,
  input  byte_t  data_in,
  output addr_t  addr,
  output logic   retire,
  output trace_t trace
);

  // Vector load unit
  logic  vec_busy;
  logic  vec_load;
  addr_t vec_addr;
  addr_t vec_pc;

  // Fetch side
  addr_t   pc;
  opcode_u ir;
  byte_t   pb;
  logic    exec;

  // Execute side
  alu_ctrl_t ctrl;
  alu_res_t  res;
  byte_t     a;
  byte_t     b;
  byte_t     cc;

  // --------------------------------------------------------------------------
  // Address bus
  // --------------------------------------------------------------------------
  // Vector loader owns the bus until pc holds the vector
  assign addr = vec_busy ? vec_addr : pc;

  vector_loader i_vector_loader (
    .clk      (clk),
    .reset_b  (reset_b),
    .data_in  (data_in),
    .vec_busy (vec_busy),
    .vec_addr (vec_addr),
    .vec_load (vec_load),
    .vec_pc   (vec_pc)
  );

  fetch_unit i_fetch_unit (
    .clk      (clk),
    .reset_b  (reset_b),
    .data_in  (data_in),
    .vec_busy (vec_busy),
    .vec_load (vec_load),
    .vec_pc   (vec_pc),
    .pc       (pc),
    .ir       (ir),
    .pb       (pb),
    .exec     (exec)
  );

  op_decode i_op_decode (
    .ir   (ir),
    .ctrl (ctrl)
  );

  alu i_alu (
    .ctrl (ctrl),
    .a    (a),
    .b    (b),
    .pb   (pb),
    .cc   (cc),
    .res  (res)
  );

  exec_regs i_exec_regs (
    .clk     (clk),
    .reset_b (reset_b),
    .exec    (exec),
    .ctrl    (ctrl),
    .res     (res),
    .pc      (pc),
    .a       (a),
    .b       (b),
    .cc      (cc),
    .retire  (retire),
    .trace   (trace)
  );

endmodule

// File: hdl/exec_regs.sv
// Accumulator and CC registers with writeback and the retire trace register

`timescale 1ns/100ps

module exec_regs import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset_b,
  input  logic      exec,
  input  alu_ctrl_t ctrl,
  input  alu_res_t  res,
  input  addr_t     pc,
  output byte_t     a,
  output byte_t     b,
  output byte_t     cc,
  output logic      retire,
  output trace_t    trace
);

  byte_t a_d;
  byte_t b_d;
  byte_t cc_d;

  // --------------------------------------------------------------------------
  // Writeback
  // --------------------------------------------------------------------------
  always_comb begin
    a_d  = a;
    b_d  = b;
    cc_d = cc;
    if (exec) begin
      if (ctrl.dest_a) begin
        a_d = res.result;
      end
      if (ctrl.dest_b) begin
        b_d = res.result;
      end
      // E, F, H and I never move
      if (ctrl.op != ALU_NONE) begin
        cc_d[CC_N] = res.n;
        cc_d[CC_Z] = res.z;
        cc_d[CC_V] = res.v;
        cc_d[CC_C] = res.c;
      end
    end
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a      <= 8'h00;
      b      <= 8'h00;
      cc     <= CC_RESET;
      retire <= 1'b0;
    end else begin
      a      <= a_d;
      b      <= b_d;
      cc     <= cc_d;
      retire <= exec;
    end
  end

  // Snapshot of post-execute state
  // pc already points past the executed instruction
  always_ff @(posedge clk) begin
    if (exec) begin
      trace <= '{pc: pc, a: a_d, b: b_d, cc: cc_d};
    end
  end

endmodule

// File: hdl/alu.sv
// 8-bit accumulator operators with N, Z, V and C results

`timescale 1ns/100ps

module alu import cpu_pkg::*; (
  input  alu_ctrl_t ctrl,
  input  byte_t     a,
  input  byte_t     b,
  input  byte_t     pb,
  input  byte_t     cc,
  output alu_res_t  res
);

  byte_t operand;
  byte_t result;
  logic  c_in;
  logic  c_out;
  logic  v_out;

  // --------------------------------------------------------------------------
  // Operand select
  // --------------------------------------------------------------------------
  // Immediate byte for loads
  assign operand = (ctrl.op == ALU_LD) ? pb : (ctrl.src_b ? b : a);
  assign c_in    = cc[CC_C];

  // --------------------------------------------------------------------------
  // Operators
  // --------------------------------------------------------------------------
  always_comb begin
    // Pass through with flags held
    result = operand;
    c_out  = c_in;
    v_out  = cc[CC_V];

    case (ctrl.op)
      ALU_CLR: begin
        result = 8'h00;
        c_out  = 1'b0;
        v_out  = 1'b0;
      end
      ALU_INC: begin
        // Carry untouched
        result = operand + 8'd1;
        v_out  = (result == 8'h80);
      end
      ALU_COM: begin
        result = ~operand;
        c_out  = 1'b1;
        v_out  = 1'b0;
      end
      ALU_ASL: begin
        result = {operand[6:0], 1'b0};
        c_out  = operand[7];
        v_out  = result[7] ^ c_out;
      end
      ALU_ROL: begin
        result = {operand[6:0], c_in};
        c_out  = operand[7];
        v_out  = result[7] ^ c_out;
      end
      ALU_LSR: begin
        result = {1'b0, operand[7:1]};
        c_out  = operand[0];
        v_out  = result[7] ^ c_out;
      end
      ALU_ASR: begin
        // Sign bit kept
        result = {operand[7], operand[7:1]};
        c_out  = operand[0];
        v_out  = result[7] ^ c_out;
      end
      ALU_ROR: begin
        result = {c_in, operand[7:1]};
        c_out  = operand[0];
        v_out  = result[7] ^ c_out;
      end
      ALU_LD: begin
        v_out  = 1'b0;
      end
      default: begin
      end
    endcase
  end

  assign res = '{result: result, n: result[7], z: (result == 8'h00), v: v_out, c: c_out};

endmodule

// File: hdl/op_decode.sv
// Opcode decoder producing ALU operation and accumulator selects

`timescale 1ns/100ps

module op_decode import cpu_pkg::*; (
  input  opcode_u   ir,
  output alu_ctrl_t ctrl
);

  logic inh_a;
  logic inh_b;

  // Inherent accumulator group
  assign inh_a = (ir.f.mode == MODE_INH_A);
  assign inh_b = (ir.f.mode == MODE_INH_B);

  always_comb begin
    // Anything unknown is a no-op
    ctrl.op     = ALU_NONE;
    ctrl.src_b  = 1'b0;
    ctrl.dest_a = 1'b0;
    ctrl.dest_b = 1'b0;

    if (ir.raw == LDA_IMM) begin
      ctrl.op     = ALU_LD;
      ctrl.dest_a = 1'b1;
    end else if (ir.raw == LDB_IMM) begin
      ctrl.op     = ALU_LD;
      ctrl.dest_b = 1'b1;
    end else if (inh_a || inh_b) begin
      // Low nibble names the operator
      case (ir.f.op)
        OP_CLR: ctrl.op = ALU_CLR;
        OP_INC: ctrl.op = ALU_INC;
        OP_COM: ctrl.op = ALU_COM;
        OP_ASL: ctrl.op = ALU_ASL;
        OP_ASR: ctrl.op = ALU_ASR;
        OP_LSR: ctrl.op = ALU_LSR;
        OP_ROL: ctrl.op = ALU_ROL;
        OP_ROR: ctrl.op = ALU_ROR;
        default: ctrl.op = ALU_NONE;
      endcase
      // No destination for unimplemented inherent ops
      if (ctrl.op != ALU_NONE) begin
        ctrl.src_b  = inh_b;
        ctrl.dest_a = inh_a;
        ctrl.dest_b = inh_b;
      end
    end
  end

endmodule

// File: hdl/fetch_unit.sv
// Instruction fetch FSM with program counter, instruction and post-byte registers

`timescale 1ns/100ps

module fetch_unit import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset_b,
  input  byte_t   data_in,
  input  logic    vec_busy,
  input  logic    vec_load,
  input  addr_t   vec_pc,
  output addr_t   pc,
  output opcode_u ir,
  output byte_t   pb,
  output logic    exec
);

  // --------------------------------------------------------------------------
  // One-hot fetch state
  // --------------------------------------------------------------------------
  localparam logic [3:0] ST_VECTOR  = 4'b0001;  // Waiting for the vector
  localparam logic [3:0] ST_WAIT    = 4'b0010;  // Bus still with the loader
  localparam logic [3:0] ST_OPCODE  = 4'b0100;  // ir valid
  localparam logic [3:0] ST_OPERAND = 4'b1000;  // pb valid

  logic [3:0] state_q;
  logic [3:0] state_d;
  logic       in_vector;
  logic       in_wait;
  logic       in_opcode;
  logic       in_operand;
  logic       is_imm;
  logic       fetch;
  logic       ir_load;

  assign in_vector  = state_q[0];
  assign in_wait    = state_q[1];
  assign in_opcode  = state_q[2];
  assign in_operand = state_q[3];

  // Only the two immediate loads carry an operand byte
  assign is_imm = (ir.raw == LDA_IMM) || (ir.raw == LDB_IMM);

  // One byte per cycle once the bus is ours
  assign fetch   = (in_wait & ~vec_busy) | in_opcode | in_operand;
  assign ir_load = (in_wait & ~vec_busy) | (in_opcode & ~is_imm) | in_operand;

  // Inherent ops run while the next opcode arrives
  // Loads run in the cycle after the operand arrives
  assign exec = (in_opcode & ~is_imm) | in_operand;

  always_comb begin
    state_d = state_q;
    if (in_vector && vec_load) begin
      state_d = ST_WAIT;
    end
    if (in_wait && !vec_busy) begin
      state_d = ST_OPCODE;
    end
    if (in_opcode && is_imm) begin
      state_d = ST_OPERAND;
    end
    if (in_operand) begin
      state_d = ST_OPCODE;
    end
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state_q <= ST_VECTOR;
      pc      <= '0;
      ir.raw  <= '0;
    end else begin
      state_q <= state_d;
      // pc points at the byte on the bus
      if (in_vector && vec_load) begin
        pc <= vec_pc;
      end else if (fetch) begin
        pc <= pc + 16'd1;
      end
      if (ir_load) begin
        ir.raw <= data_in;
      end
    end
  end

  // Immediate operand
  always_ff @(posedge clk) begin
    if (in_opcode && is_imm) begin
      pb <= data_in;
    end
  end

endmodule

// File: hdl/vector_loader.sv
// Reset vector loader reading the two big-endian vector bytes

`timescale 1ns/100ps

module vector_loader import cpu_pkg::*; (
  input  logic  clk,
  input  logic  reset_b,
  input  byte_t data_in,
  output logic  vec_busy,
  output addr_t vec_addr,
  output logic  vec_load,
  output addr_t vec_pc
);

  typedef enum logic [1:0] {
    VL_MSB,
    VL_LSB,
    VL_IDLE
  } vl_state_e;

  vl_state_e state_q;
  byte_t     msb_q;

  // --------------------------------------------------------------------------
  // Sequencer
  // --------------------------------------------------------------------------
  // Runs once after reset then parks in idle
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state_q  <= VL_MSB;
      vec_addr <= RESET_VECTOR;
    end else begin
      case (state_q)
        VL_MSB: begin
          state_q  <= VL_LSB;
          vec_addr <= vec_addr + 16'd1;
        end
        VL_LSB: state_q <= VL_IDLE;
        default: state_q <= VL_IDLE;
      endcase
    end
  end

  // High byte staged for the LSB cycle
  always_ff @(posedge clk) begin
    if (state_q == VL_MSB) begin
      msb_q <= data_in;
    end
  end

  assign vec_busy = (state_q != VL_IDLE);
  assign vec_load = (state_q == VL_LSB);
  // LSB comes straight off the bus
  assign vec_pc   = {msb_q, data_in};

endmodule

// File: hdl/cpu_pkg.sv
// Shared widths, CC layout, opcode fields, ALU controls and trace record

package cpu_pkg;

  // --------------------------------------------------------------------------
  // Basic widths
  // --------------------------------------------------------------------------
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;

  // MSB of the big-endian reset vector
  // LSB sits at the next address
  localparam addr_t RESET_VECTOR = 16'hfffe;

  // E, F and I set out of reset
  localparam byte_t CC_RESET = 8'b1101_0000;

  // Condition code bit positions
  localparam int CC_E = 7;
  localparam int CC_F = 6;
  localparam int CC_H = 5;
  localparam int CC_I = 4;
  localparam int CC_N = 3;
  localparam int CC_Z = 2;
  localparam int CC_V = 1;
  localparam int CC_C = 0;

  // --------------------------------------------------------------------------
  // Opcode views
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [3:0] mode;
    logic [3:0] op;
  } opcode_fields_t;

  // Raw byte for whole-opcode compares, nibbles for the inherent group
  typedef union packed {
    byte_t          raw;
    opcode_fields_t f;
  } opcode_u;

  // Immediate loads
  localparam byte_t LDA_IMM = 8'h86;
  localparam byte_t LDB_IMM = 8'hc6;

  // Inherent modes, one per accumulator
  localparam logic [3:0] MODE_INH_A = 4'h4;
  localparam logic [3:0] MODE_INH_B = 4'h5;

  // Low nibble of the inherent group
  localparam logic [3:0] OP_COM = 4'h3;
  localparam logic [3:0] OP_LSR = 4'h4;
  localparam logic [3:0] OP_ROR = 4'h6;
  localparam logic [3:0] OP_ASR = 4'h7;
  localparam logic [3:0] OP_ASL = 4'h8;
  localparam logic [3:0] OP_ROL = 4'h9;
  localparam logic [3:0] OP_INC = 4'hc;
  localparam logic [3:0] OP_CLR = 4'hf;

  // --------------------------------------------------------------------------
  // ALU interface
  // --------------------------------------------------------------------------
  typedef enum logic [3:0] {
    ALU_NONE, ALU_CLR, ALU_INC, ALU_COM, ALU_ASL,
    ALU_ASR, ALU_LSR, ALU_ROL, ALU_ROR, ALU_LD
  } alu_op_e;

  typedef struct packed {
    alu_op_e op;
    logic    src_b;   // Operand from B instead of A
    logic    dest_a;
    logic    dest_b;
  } alu_ctrl_t;

  typedef struct packed {
    byte_t result;
    logic  n;
    logic  z;
    logic  v;
    logic  c;
  } alu_res_t;

  // Retired architectural state
  typedef struct packed {
    addr_t pc;
    byte_t a;
    byte_t b;
    byte_t cc;
  } trace_t;

endpackage
